//--- hdl/macPkg.sv
package macPkg;

	localparam int opWidth = 30;
	localparam int accWidth = 60;
	localparam int multWidth = 32; // Wide enough for 3x the multiplicand

	// One radix-4 digit per iteration
	localparam int numIter = opWidth / 2;

	typedef enum logic [1:0] {
		opMul = 2'd0, // Result becomes the product
		opMac = 2'd1, // Product added to the accumulator
		opClr = 2'd2
	} macOp;

	typedef enum logic [1:0] {
		stIdle = 2'd0,
		stPre  = 2'd1, // Adder busy forming 3x multiplicand
		stIter = 2'd2,
		stDone = 2'd3
	} macState;

endpackage

//--- hdl/rippleAdder60.sv
`timescale 1ns/1ps

module rippleAdder60 (
	input  logic [macPkg::accWidth-1:0] a,
	input  logic [macPkg::accWidth-1:0] b,
	output logic [macPkg::accWidth:0]   sum
);
	import macPkg::*;

	genvar i;
	generate
		for (i = 0; i < accWidth; i++) begin : gBit
			logic co; // Carry out of this bit cell

			if (i == 0) begin : gHalf
				// No carry into the LSB
				assign sum[i] = a[i] ^ b[i];
				assign co = a[i] & b[i];
			end else begin : gFull
				logic p;

				assign p = a[i] ^ b[i]; // Propagate
				assign sum[i] = p ^ gBit[i-1].co;
				assign co = (a[i] & b[i]) | (p & gBit[i-1].co);
			end
		end
	endgenerate

	assign sum[accWidth] = gBit[accWidth-1].co; // Carry-out of the MSB

endmodule

//--- hdl/digitSelect.sv
`timescale 1ns/1ps

module digitSelect (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic                        loadOps,
	input  logic                        preCalc,
	input  logic                        iterEn,
	input  logic [3:0]                  digitIdx,
	input  logic [macPkg::opWidth-1:0]  opA,
	input  logic [macPkg::opWidth-1:0]  opB,
	input  logic [macPkg::accWidth-1:0] acc,
	input  logic [macPkg::accWidth:0]   sum,
	output logic [macPkg::accWidth-1:0] addA,
	output logic [macPkg::accWidth-1:0] addB
);
	import macPkg::*;

	logic [opWidth-1:0]   mcand;  // Multiplicand
	logic [opWidth-1:0]   mplier; // Multiplier, scanned two bits at a time
	logic [multWidth-1:0] triple;
	logic [4:0]           shiftAmt;
	logic [1:0]           digit;
	logic [multWidth-1:0] multiple;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mcand <= '0;
			mplier <= '0;
		end else if (loadOps) begin
			mcand <= opA;
			mplier <= opB;
		end
	end

	// The adder result during precalc is 2x + 1x
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			triple <= '0;
		end else if (preCalc) begin
			triple <= sum[multWidth-1:0];
		end
	end

	assign shiftAmt = {digitIdx, 1'b0}; // Digit weight is 4^digitIdx
	assign digit = 2'(mplier >> shiftAmt);

	always_comb begin
		case (digit)
			2'd0: multiple = '0;
			2'd1: multiple = {2'b00, mcand};
			2'd2: multiple = {1'b0, mcand, 1'b0};
			default: multiple = triple;
		endcase
	end

	always_comb begin
		addA = acc;
		addB = '0;
		if (preCalc) begin
			addA = {{(accWidth-opWidth-1){1'b0}}, mcand, 1'b0};
			addB = {{(accWidth-opWidth){1'b0}}, mcand};
		end else if (iterEn) begin
			// Partial product lined up with its digit, added onto the running sum
			addB = {{(accWidth-multWidth){1'b0}}, multiple} << shiftAmt;
		end
	end

endmodule

//--- hdl/accumulator.sv
`timescale 1ns/1ps

module accumulator (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic                        accClr,
	input  logic                        accWrite,
	input  logic                        ovfClr,
	input  logic                        ovfEn,
	input  logic [macPkg::accWidth:0]   sum,
	output logic [macPkg::accWidth-1:0] acc,
	output logic                        ovf
);
	import macPkg::*;

	logic carryOut;

	assign carryOut = sum[accWidth];

	// Running sum, doubles as the result
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			acc <= '0;
		end else if (accClr) begin
			acc <= '0;
		end else if (accWrite) begin
			acc <= sum[accWidth-1:0]; // Wraps modulo 2^60
		end
	end

	// Sticky until a clear
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ovf <= 1'b0;
		end else if (ovfClr) begin
			ovf <= 1'b0;
		end else if (ovfEn) begin
			ovf <= ovf | carryOut;
		end
	end

endmodule

//--- hdl/macControl.sv
`timescale 1ns/1ps

module macControl (
	input  logic         clk,
	input  logic         arstN,
	input  logic         start,
	input  macPkg::macOp op,
	output logic         busy,
	output logic         done,
	output logic         loadOps,
	output logic         preCalc,
	output logic         iterEn,
	output logic         accClr,
	output logic         accWrite,
	output logic         ovfClr,
	output logic         ovfEn,
	output logic [3:0]   digitIdx
);
	import macPkg::*;

	macState state;
	macState nextState;
	logic    accept;
	logic    isMulOrMac;
	logic    lastDigit;
	logic    isMac; // Op of the operation in flight

	assign accept = start && (state == stIdle); // Starts while busy are dropped
	assign isMulOrMac = (op == opMul) || (op == opMac);
	assign lastDigit = (digitIdx == 4'(numIter - 1));

	always_comb begin
		nextState = state;
		case (state)
			stIdle: begin
				if (accept && op == opClr) begin
					nextState = stDone;
				end else if (accept && isMulOrMac) begin
					nextState = stPre;
				end
			end
			stPre: nextState = stIter;
			stIter: begin
				if (lastDigit) begin
					nextState = stDone;
				end
			end
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			isMac <= 1'b0;
		end else if (accept) begin
			isMac <= (op == opMac);
		end
	end

	// Restarted in the precalc cycle so digit 0 comes first
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			digitIdx <= '0;
		end else if (preCalc) begin
			digitIdx <= '0;
		end else if (iterEn) begin
			digitIdx <= digitIdx + 4'd1;
		end
	end

	assign busy = (state != stIdle);
	assign done = (state == stDone);
	assign loadOps = accept && isMulOrMac;
	assign accClr = accept && ((op == opClr) || (op == opMul));
	assign ovfClr = accept && (op == opClr);
	assign preCalc = (state == stPre);
	assign iterEn = (state == stIter);
	assign accWrite = iterEn;
	assign ovfEn = iterEn && isMac; // MUL never carries out

endmodule

//--- hdl/macTop.sv
`timescale 1ns/1ps

module macTop (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic                        start,
	input  macPkg::macOp                op,
	input  logic [macPkg::opWidth-1:0]  opA,
	input  logic [macPkg::opWidth-1:0]  opB,
	output logic                        busy,
	output logic                        done,
	output logic [macPkg::accWidth-1:0] result,
	output logic                        ovf
);
	import macPkg::*;

	logic                loadOps;
	logic                preCalc;
	logic                iterEn;
	logic [3:0]          digitIdx;
	logic                accClr;
	logic                accWrite;
	logic                ovfClr;
	logic                ovfEn;
	logic [accWidth-1:0] addA;
	logic [accWidth-1:0] addB;
	logic [accWidth:0]   sum; // Shared adder output with carry-out

	macControl u_macControl (
		.clk      (clk),
		.arstN    (arstN),
		.start    (start),
		.op       (op),
		.busy     (busy),
		.done     (done),
		.loadOps  (loadOps),
		.preCalc  (preCalc),
		.iterEn   (iterEn),
		.accClr   (accClr),
		.accWrite (accWrite),
		.ovfClr   (ovfClr),
		.ovfEn    (ovfEn),
		.digitIdx (digitIdx)
	);

	digitSelect u_digitSelect (
		.clk      (clk),
		.arstN    (arstN),
		.loadOps  (loadOps),
		.preCalc  (preCalc),
		.iterEn   (iterEn),
		.digitIdx (digitIdx),
		.opA      (opA),
		.opB      (opB),
		.acc      (result), // Accumulator fed back as the addend
		.sum      (sum),
		.addA     (addA),
		.addB     (addB)
	);

	rippleAdder60 u_rippleAdder60 (
		.a   (addA),
		.b   (addB),
		.sum (sum)
	);

	accumulator u_accumulator (
		.clk      (clk),
		.arstN    (arstN),
		.accClr   (accClr),
		.accWrite (accWrite),
		.ovfClr   (ovfClr),
		.ovfEn    (ovfEn),
		.sum      (sum),
		.acc      (result),
		.ovf      (ovf)
	);

endmodule

//--- bench/macTb_sva.sv
`timescale 1ns/1ps

module macTb_sva (
	input logic            clk,
	input logic            arstN,
	input logic            start,
	input macPkg::macOp    op,
	input macPkg::macState state,
	input logic            busy,
	input logic            done
);
	import macPkg::*;

	localparam int mulLatency = 17;

	logic mulStart; // Accepted MUL or MAC

	assign mulStart = start && (state == stIdle) && ((op == opMul) || (op == opMac));

	donePulse: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
		else $error("done held for more than one cycle");

	// Once busy, it stays high through the done cycle
	busyHold: assert property (@(posedge clk) disable iff (!arstN) (busy && !done) |=> busy)
		else $error("busy dropped before done");

	doneLatency: assert property (@(posedge clk) disable iff (!arstN)
		mulStart |-> ##mulLatency done)
		else $error("done not on time after a MUL or MAC start");

	resetIdle: assert property (@(posedge clk)
		$rose(arstN) |-> (!busy && !done && state == stIdle))
		else $error("controller not idle out of reset");

endmodule

bind macControl macTb_sva u_macTbSva (
	.clk   (clk),
	.arstN (arstN),
	.start (start),
	.op    (op),
	.state (state),
	.busy  (busy),
	.done  (done)
);

//--- bench/macTb.sv
`timescale 1ns/1ps

module macTb;
	import macPkg::*;

	localparam int clkHalf = 10;
	localparam int resetCycles = 10;
	localparam int doneTimeout = 40;
	localparam int mulLatency = 17; // Start edge to done, MUL and MAC
	localparam int clrLatency = 1;
	localparam int strayDelay = 3;
	localparam int quietCycles = 2;

	logic                clk;
	logic                arstN;
	logic                start;
	macOp                op;
	logic [opWidth-1:0]  opA;
	logic [opWidth-1:0]  opB;
	logic                busy;
	logic                done;
	logic [accWidth-1:0] result;
	logic                ovf;

	int valueErrors;
	int otherErrors;
	int timeouts;
	int casesRun;

	macTop u_macTop (
		.clk    (clk),
		.arstN  (arstN),
		.start  (start),
		.op     (op),
		.opA    (opA),
		.opB    (opB),
		.busy   (busy),
		.done   (done),
		.result (result),
		.ovf    (ovf)
	);

	initial clk = 1'b0;
	always #(clkHalf) clk = ~clk;

	task automatic checkResult(input string name, input logic [accWidth-1:0] expected,
			input logic [accWidth-1:0] actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkOvf(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic reportFailure(input string what);
		otherErrors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	// Pulses start for one cycle, then waits for done counting cycles from the start edge
	task automatic runOp(input macOp opIn, input logic [opWidth-1:0] a,
			input logic [opWidth-1:0] b, input logic stray, output int latency,
			output logic gotDone);
		int   cycles;
		logic seen;

		@(posedge clk);
		start <= 1'b1;
		op <= opIn;
		opA <= a;
		opB <= b;
		@(posedge clk); // DUT samples start here
		start <= 1'b0;
		cycles = 0;
		seen = 1'b0;
		if (stray) begin
			// Second start while busy, must be dropped
			repeat (strayDelay) @(posedge clk);
			start <= 1'b1;
			op <= opClr;
			opA <= '1;
			opB <= '1;
			@(posedge clk);
			start <= 1'b0;
			op <= opIn;
			cycles = strayDelay + 1;
		end
		while (!seen && cycles < doneTimeout) begin
			@(negedge clk);
			cycles++;
			seen = done;
		end
		latency = cycles;
		gotDone = seen;
	endtask

	// Result holds and no further done shows up
	task automatic checkAfterDone(input logic [accWidth-1:0] expRes, input logic expOvf);
		repeat (quietCycles) begin
			@(negedge clk);
			if (done) begin
				reportFailure("done is high again after its pulse");
			end
			if (busy) begin
				reportFailure("busy is still high after done");
			end
			checkResult("result", expRes, result);
			checkOvf("ovf", expOvf, ovf);
		end
	endtask

	task automatic runCase(input logic [3:0] opField, input logic [opWidth-1:0] a,
			input logic [opWidth-1:0] b, input logic [accWidth-1:0] expRes, input logic expOvf);
		macOp opIn;
		logic stray;
		int   latency;
		int   expLatency;
		logic gotDone;

		opIn = macOp'(opField[1:0]);
		stray = opField[2];
		expLatency = (opIn == opClr) ? clrLatency : mulLatency;
		runOp(opIn, a, b, stray, latency, gotDone);
		casesRun++;
		if (!gotDone) begin
			timeouts++;
			$display("Timeout: case %0d got no done within %0d cycles", casesRun, doneTimeout);
		end else begin
			if (latency != expLatency) begin
				reportFailure($sformatf("case %0d: done came %0d cycles after start, not %0d",
					casesRun, latency, expLatency));
			end
			if (!busy) begin
				reportFailure($sformatf("case %0d: busy is low in the done cycle", casesRun));
			end
			checkResult("result", expRes, result);
			checkOvf("ovf", expOvf, ovf);
			checkAfterDone(expRes, expOvf);
		end
	endtask

	initial begin
		string               line;
		int                  fd;
		int                  n;
		logic [3:0]          opField;
		logic [opWidth-1:0]  a;
		logic [opWidth-1:0]  b;
		logic [accWidth-1:0] expRes;
		logic                expOvf;

		arstN = 1'b0;
		start = 1'b0;
		op = opMul;
		opA = '0;
		opB = '0;
		valueErrors = 0;
		otherErrors = 0;
		timeouts = 0;
		casesRun = 0;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkResult("result", '0, result);
		checkOvf("ovf", 1'b0, ovf);
		if (busy || done) begin
			reportFailure("busy or done is high after reset");
		end

		fd = $fopen("bench/macCases.txt", "r");
		if (fd == 0) begin
			reportFailure("could not open bench/macCases.txt");
		end else begin
			while (!$feof(fd) && timeouts == 0) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() <= 1 || line.getc(0) == 8'h23) begin
					continue; // Blank or comment line
				end
				n = $sscanf(line, "%h %h %h %h %h", opField, a, b, expRes, expOvf);
				if (n != 5) begin
					reportFailure($sformatf("case file line is malformed: %s", line));
					continue;
				end
				runCase(opField, a, b, expRes, expOvf);
			end
			$fclose(fd);
		end
		if (casesRun == 0) begin
			reportFailure("no cases were run");
		end

		$display("Errors: %0d value, %0d other, %0d timeout, %0d cases run",
			valueErrors, otherErrors, timeouts, casesRun);
		if (valueErrors == 0 && otherErrors == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- bench/macCases.txt
# op opA opB expResult expOvf, all hex
# op: 0 MUL, 1 MAC, 2 CLR; add 4 to also pulse start while busy
0 00000000 00000000 000000000000000 0
0 00000001 00000001 000000000000001 0
0 3FFFFFFF 3FFFFFFF FFFFFFF80000001 0
0 3FFFFFFF 00000000 000000000000000 0
0 00000000 3FFFFFFF 000000000000000 0
0 3FFFFFFF 00000001 00000003FFFFFFF 0
0 3FFFFFFF 00000008 0000001FFFFFFF8 0
0 3FFFFFFF 00000010 0000003FFFFFFF0 0
0 3FFFFFFF 00000080 000001FFFFFFF80 0
0 3FFFFFFF 00000100 000003FFFFFFF00 0
0 3FFFFFFF 00000800 00001FFFFFFF800 0
0 3FFFFFFF 00001000 00003FFFFFFF000 0
0 3FFFFFFF 00008000 0001FFFFFFF8000 0
0 3FFFFFFF 00010000 0003FFFFFFF0000 0
0 3FFFFFFF 00080000 001FFFFFFF80000 0
0 3FFFFFFF 00100000 003FFFFFFF00000 0
0 3FFFFFFF 00800000 01FFFFFFF800000 0
0 3FFFFFFF 01000000 03FFFFFFF000000 0
0 3FFFFFFF 08000000 1FFFFFFF8000000 0
0 3FFFFFFF 10000000 3FFFFFFF0000000 0
2 00000000 00000000 000000000000000 0
1 00000003 0000001B 000000000000051 0
1 00001000 000000E4 0000000000E4051 0
1 3FFFFFFF 000000FF 000003FC00E3F52 0
0 3FFFFFFF 3FFFFFFF FFFFFFF80000001 0
1 3FFFFFFF 3FFFFFFF FFFFFFF00000002 1
1 3FFFFFFF 3FFFFFFF FFFFFFE80000003 1
0 00000002 00000003 000000000000006 1
1 00000001 00000001 000000000000007 1
2 00000000 00000000 000000000000000 0
1 3FFFFFFF 3FFFFFFF FFFFFFF80000001 0
1 3FFFFFFF 00000002 FFFFFFFFFFFFFFF 0
1 00000001 00000001 000000000000000 1
2 3FFFFFFF 3FFFFFFF 000000000000000 0
4 00010001 00000303 000000003030303 0
5 00000100 00000101 000000003040403 0
2 00000000 00000000 000000000000000 0

//--- vlog.f
hdl/macPkg.sv
hdl/rippleAdder60.sv
hdl/digitSelect.sv
hdl/accumulator.sv
hdl/macControl.sv
hdl/macTop.sv
bench/macTb_sva.sv
bench/macTb.sv

//--- run.sh
#!/bin/bash
# Build and run the MAC testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f vlog.f --top-module macTb \
	-Mdir "$buildDir" -o macTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/macTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
fi

grep -qx "Simulation finished: PASS" "$logFile"
if [ $? -ne 0 ]; then
	echo "Pass line not found in $logFile"
	exit 1
fi
exit 0
